// ==== list.f ====
common/mem_pkg.sv
mem_ctrl/line_burst_engine.sv
mem_ctrl/ptw_arbiter.sv
mem_ctrl/mem_port_mux.sv
logic/mem_subsystem_top.sv
tb/mem_model.sv
tb/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsystem \
    -f list.f -o sim_mem_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_subsystem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int             NUM_WALKERS = 4;
    localparam int             TIMEOUT     = 200;
    localparam int             RR_ROUNDS   = 3;
    localparam int             NUM_ROWS    = 15;
    localparam int             WORD_W      = $bits(mem_pkg::word_t);
    localparam mem_pkg::word_t FILL        = 64'h5a5a_0000_0000_0000;

    typedef enum logic [2:0] {
        K_LINE_RD,
        K_LINE_WR,
        K_WALK_RD,
        K_WALK_WR,
        K_MIXED,
        K_ROTATE
    } kind_t;

    typedef struct packed {
        kind_t          kind;
        logic [1:0]     port;
        mem_pkg::addr_t addr;
        mem_pkg::word_t wdata;
        logic           exp_err;
    } row_t;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 line_req;
    mem_pkg::line_cmd_t                   line_cmd;
    logic                                 line_ack;
    mem_pkg::line_rsp_t                   line_rsp;
    logic [NUM_WALKERS-1:0]               ptw_req;
    mem_pkg::word_cmd_t [NUM_WALKERS-1:0] ptw_cmd;
    logic [NUM_WALKERS-1:0]               ptw_ack;
    mem_pkg::word_rsp_t [NUM_WALKERS-1:0] ptw_rsp;
    logic                                 mem_request;
    mem_pkg::word_cmd_t                   mem_cmd;
    logic                                 mem_ready;
    mem_pkg::word_t                       mem_read_data;
    logic                                 mem_error;

    row_t           rows [NUM_ROWS];
    mem_pkg::word_t shadow [mem_pkg::addr_t];
    int             ack_order [$];
    int             checks;
    int             errors;
    int             timeouts;

    mem_subsystem_top #(
        .NUM_WALKERS (NUM_WALKERS)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .line_req      (line_req),
        .line_cmd      (line_cmd),
        .line_ack      (line_ack),
        .line_rsp      (line_rsp),
        .ptw_req       (ptw_req),
        .ptw_cmd       (ptw_cmd),
        .ptw_ack       (ptw_ack),
        .ptw_rsp       (ptw_rsp),
        .mem_request   (mem_request),
        .mem_cmd       (mem_cmd),
        .mem_ready     (mem_ready),
        .mem_read_data (mem_read_data),
        .mem_error     (mem_error)
    );

    mem_model mem0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_request   (mem_request),
        .mem_cmd       (mem_cmd),
        .mem_ready     (mem_ready),
        .mem_read_data (mem_read_data),
        .mem_error     (mem_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Reference values
    // ========================================
    function automatic mem_pkg::word_t expected_word(input mem_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {32'h0, a} ^ FILL;
    endfunction

    // Line write data derived from one seed word
    function automatic mem_pkg::line_t make_line(input mem_pkg::word_t seed);
        mem_pkg::line_t l;
        for (int k = 0; k < mem_pkg::LINE_WORDS; k++) begin
            l[k*WORD_W +: WORD_W] = seed + mem_pkg::word_t'(k) * 64'h0101_0101_0101_0101;
        end
        return l;
    endfunction

    // ========================================
    // Line port transaction
    // ========================================
    task automatic run_line(input mem_pkg::addr_t addr, input logic write,
                            input mem_pkg::word_t seed, input logic exp_err);
        mem_pkg::line_t     wline;
        mem_pkg::line_rsp_t rsp;
        mem_pkg::word_t     exp_w;
        mem_pkg::addr_t     exp_a;
        int                 wait_cnt;
        int                 log_start;
        int                 first;
        wline     = make_line(seed);
        log_start = mem0.log_cnt;
        @(posedge clk);
        line_req       <= 1'b1;
        line_cmd.addr  <= addr;
        line_cmd.wdata <= wline;
        line_cmd.write <= write;
        wait_cnt = 0;
        @(posedge clk);
        while (!line_ack && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        rsp = line_rsp;
        line_req <= 1'b0;
        if (!line_ack) begin
            timeouts++;
            $display("Timeout: line_ack never rose for the line at %h", addr);
        end else begin
            checks++;
            if (rsp.error !== exp_err) begin
                errors++;
                $display("[FAIL] line_rsp.error at %h: got %h, expected %h", addr, rsp.error,
                         exp_err);
            end
            for (int k = 0; k < mem_pkg::LINE_WORDS; k++) begin
                exp_a = addr + mem_pkg::addr_t'(k * mem_pkg::WORD_BYTES);
                if (write) begin
                    shadow[exp_a] = wline[k*WORD_W +: WORD_W];
                end else begin
                    exp_w = expected_word(exp_a);
                    checks++;
                    if (rsp.rdata[k*WORD_W +: WORD_W] !== exp_w) begin
                        errors++;
                        $display("[FAIL] line_rsp.rdata word %0d at %h: got %h, expected %h",
                                 k, addr, rsp.rdata[k*WORD_W +: WORD_W], exp_w);
                    end
                end
            end
        end
        // Burst must show up in the log as eight back-to-back words
        first = -1;
        for (int i = log_start; i < mem0.log_cnt; i++) begin
            if (first < 0 && mem0.log_addr[i] == addr) begin
                first = i;
            end
        end
        checks++;
        if (first < 0 || first + mem_pkg::LINE_WORDS > mem0.log_cnt) begin
            errors++;
            $display("Memory log holds no complete burst for the line at %h", addr);
        end else begin
            for (int k = 0; k < mem_pkg::LINE_WORDS; k++) begin
                exp_a = addr + mem_pkg::addr_t'(k * mem_pkg::WORD_BYTES);
                if (mem0.log_addr[first+k] !== exp_a) begin
                    errors++;
                    $display("[FAIL] mem_cmd.addr in burst slot %0d: got %h, expected %h",
                             k, mem0.log_addr[first+k], exp_a);
                end
                if (mem0.log_write[first+k] !== write) begin
                    errors++;
                    $display("[FAIL] mem_cmd.write in burst slot %0d: got %h, expected %h",
                             k, mem0.log_write[first+k], write);
                end
            end
        end
        wait_cnt = 0;
        while (line_ack && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (line_ack) begin
            timeouts++;
            $display("Timeout: line_ack stayed high after the request was dropped");
        end
    endtask

    // ========================================
    // Walker port transaction
    // ========================================
    task automatic run_walker(input int j, input mem_pkg::addr_t addr, input logic write,
                              input mem_pkg::word_t wdata, input logic exp_err);
        mem_pkg::word_cmd_t cmd;
        mem_pkg::word_rsp_t rsp;
        mem_pkg::word_t     exp_w;
        int                 wait_cnt;
        exp_w     = expected_word(addr);
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.write = write;
        @(posedge clk);
        ptw_req[j] <= 1'b1;
        ptw_cmd[j] <= cmd;
        wait_cnt = 0;
        @(posedge clk);
        while (!ptw_ack[j] && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        rsp = ptw_rsp[j];
        ptw_req[j] <= 1'b0;
        if (!ptw_ack[j]) begin
            timeouts++;
            $display("Timeout: walker %0d never got an ack for address %h", j, addr);
        end else begin
            ack_order.push_back(j);
            checks++;
            if (rsp.error !== exp_err) begin
                errors++;
                $display("[FAIL] ptw_rsp[%0d].error at %h: got %h, expected %h", j, addr,
                         rsp.error, exp_err);
            end
            if (write) begin
                shadow[addr] = wdata;
            end else if (rsp.rdata !== exp_w) begin
                errors++;
                $display("[FAIL] ptw_rsp[%0d].rdata at %h: got %h, expected %h", j, addr,
                         rsp.rdata, exp_w);
            end
        end
        wait_cnt = 0;
        while (ptw_ack[j] && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (ptw_ack[j]) begin
            timeouts++;
            $display("Timeout: walker %0d ack stayed high after release", j);
        end
    endtask

    // Keeps one walker busy and re-raises it after each release
    task automatic walker_rounds(input int j, input mem_pkg::addr_t base);
        for (int r = 0; r < RR_ROUNDS; r++) begin
            run_walker(j, base + mem_pkg::addr_t'(64 * j + 8 * r), 1'b0, '0, 1'b0);
        end
    endtask

    task automatic apply_row(input row_t r);
        case (r.kind)
            K_LINE_RD: run_line(r.addr, 1'b0, '0, r.exp_err);
            K_LINE_WR: run_line(r.addr, 1'b1, r.wdata, r.exp_err);
            K_WALK_RD: run_walker(int'(r.port), r.addr, 1'b0, '0, r.exp_err);
            K_WALK_WR: run_walker(int'(r.port), r.addr, 1'b1, r.wdata, r.exp_err);
            K_MIXED: begin
                fork
                    run_line(r.addr, 1'b0, '0, r.exp_err);
                    run_walker(0, r.addr + 32'h200, 1'b0, '0, r.exp_err);
                    run_walker(1, r.addr + 32'h208, 1'b0, '0, r.exp_err);
                    run_walker(2, r.addr + 32'h210, 1'b0, '0, r.exp_err);
                    run_walker(3, r.addr + 32'h218, 1'b0, '0, r.exp_err);
                join
            end
            default: begin
                ack_order.delete();
                fork
                    walker_rounds(0, r.addr);
                    walker_rounds(1, r.addr);
                    walker_rounds(2, r.addr);
                    walker_rounds(3, r.addr);
                join
                checks++;
                if (ack_order.size() != NUM_WALKERS * RR_ROUNDS) begin
                    errors++;
                    $display("Round-robin run collected %0d acks instead of %0d",
                             ack_order.size(), NUM_WALKERS * RR_ROUNDS);
                end
                // Each ack goes to the walker after the previous one
                for (int i = 1; i < ack_order.size(); i++) begin
                    if (ack_order[i] != (ack_order[i-1] + 1) % NUM_WALKERS) begin
                        errors++;
                        $display("[FAIL] ptw_ack order slot %0d: got %h, expected %h", i,
                                 ack_order[i], (ack_order[i-1] + 1) % NUM_WALKERS);
                    end
                end
            end
        endcase
    endtask

    // ========================================
    // Stimulus table and main sequence
    // ========================================
    initial begin
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        rst_n    = 1'b0;
        line_req = 1'b0;
        line_cmd = '0;
        ptw_req  = '0;
        ptw_cmd  = '0;

        rows[0]  = '{K_LINE_RD, 2'd0, 32'h0000_0400, 64'h0, 1'b0};
        rows[1]  = '{K_LINE_WR, 2'd0, 32'h0000_0800, 64'h1000_2000_3000_4000, 1'b0};
        rows[2]  = '{K_LINE_RD, 2'd0, 32'h0000_0800, 64'h0, 1'b0};
        rows[3]  = '{K_WALK_RD, 2'd0, 32'h0000_0100, 64'h0, 1'b0};
        rows[4]  = '{K_WALK_RD, 2'd1, 32'h0000_0108, 64'h0, 1'b0};
        rows[5]  = '{K_WALK_RD, 2'd2, 32'h0000_0110, 64'h0, 1'b0};
        rows[6]  = '{K_WALK_RD, 2'd3, 32'h0000_0118, 64'h0, 1'b0};
        rows[7]  = '{K_WALK_WR, 2'd2, 32'h0000_0c18, 64'hdead_beef_0bad_f00d, 1'b0};
        rows[8]  = '{K_LINE_RD, 2'd0, 32'h0000_0c00, 64'h0, 1'b0};
        rows[9]  = '{K_MIXED,   2'd0, 32'h0000_1000, 64'h0, 1'b0};
        rows[10] = '{K_ROTATE,  2'd0, 32'h0000_2000, 64'h0, 1'b0};
        // Error window runs from 0x3000 to 0x30ff
        rows[11] = '{K_LINE_RD, 2'd0, 32'h0000_3000, 64'h0, 1'b1};
        rows[12] = '{K_WALK_RD, 2'd1, 32'h0000_3080, 64'h0, 1'b1};
        rows[13] = '{K_LINE_RD, 2'd0, 32'h0000_2fc0, 64'h0, 1'b0};
        rows[14] = '{K_WALK_RD, 2'd3, 32'h0000_3100, 64'h0, 1'b0};

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Handshake outputs rest low out of reset
        checks++;
        if (mem_request !== 1'b0) begin
            errors++;
            $display("[FAIL] mem_request after reset: got %h, expected %h", mem_request, 1'b0);
        end
        if (line_ack !== 1'b0) begin
            errors++;
            $display("[FAIL] line_ack after reset: got %h, expected %h", line_ack, 1'b0);
        end
        if (ptw_ack !== NUM_WALKERS'(0)) begin
            errors++;
            $display("[FAIL] ptw_ack after reset: got %h, expected %h", ptw_ack,
                     NUM_WALKERS'(0));
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end

        repeat (2) @(posedge clk);
        $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_request,
    input  mem_pkg::word_cmd_t mem_cmd,
    output logic               mem_ready,
    output mem_pkg::word_t     mem_read_data,
    output logic               mem_error
);

    localparam int             DEPTH   = 4096;
    localparam int             LOG_MAX = 1024;
    localparam logic [31:0]    SEED    = 32'ha43a_75e8;
    localparam mem_pkg::word_t FILL    = 64'h5a5a_0000_0000_0000;

    mem_pkg::word_t data_q [DEPTH];
    logic           written [DEPTH];
    logic [11:0]    widx;
    logic [31:0]    lfsr;
    logic [31:0]    lfsr_next;

    // Completed accesses in order, read by the testbench
    mem_pkg::addr_t log_addr [LOG_MAX];
    logic           log_write [LOG_MAX];
    int             log_cnt;

    // Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    assign widx      = mem_cmd.addr[14:3];
    assign lfsr_next = lfsr_step(lfsr);
    assign mem_error = (mem_cmd.addr >= 32'h0000_3000) && (mem_cmd.addr <= 32'h0000_30ff);

    // Unwritten words read back as a pattern of their own address
    always_comb begin
        if (written[widx]) begin
            mem_read_data = data_q[widx];
        end else begin
            mem_read_data = {32'h0, mem_cmd.addr} ^ FILL;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr      <= SEED;
            mem_ready <= 1'b0;
            log_cnt   <= 0;
            for (int i = 0; i < DEPTH; i++) begin
                written[i] <= 1'b0;
            end
        end else begin
            // One LFSR bit per cycle decides the stall
            lfsr      <= lfsr_next;
            mem_ready <= lfsr_next[0];
            if (mem_request && mem_ready) begin
                if (log_cnt < LOG_MAX) begin
                    log_addr[log_cnt]  <= mem_cmd.addr;
                    log_write[log_cnt] <= mem_cmd.write;
                    log_cnt            <= log_cnt + 1;
                end
                if (mem_cmd.write) begin
                    data_q[widx]  <= mem_cmd.wdata;
                    written[widx] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter int NUM_WALKERS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Line port
    input  logic                                 line_req,
    input  mem_pkg::line_cmd_t                   line_cmd,
    output logic                                 line_ack,
    output mem_pkg::line_rsp_t                   line_rsp,
    // Walker ports
    input  logic [NUM_WALKERS-1:0]               ptw_req,
    input  mem_pkg::word_cmd_t [NUM_WALKERS-1:0] ptw_cmd,
    output logic [NUM_WALKERS-1:0]               ptw_ack,
    output mem_pkg::word_rsp_t [NUM_WALKERS-1:0] ptw_rsp,
    // Memory port
    output logic                                 mem_request,
    output mem_pkg::word_cmd_t                   mem_cmd,
    input  logic                                 mem_ready,
    input  mem_pkg::word_t                       mem_read_data,
    input  logic                                 mem_error
);

    // ========================================
    // Word channels into the mux
    // ========================================
    logic               line_word_req;
    mem_pkg::word_cmd_t line_word_cmd;
    logic               line_word_ready;
    logic               walk_word_req;
    mem_pkg::word_cmd_t walk_word_cmd;
    logic               walk_word_ready;
    mem_pkg::word_t     word_rdata;
    logic               word_error;

    line_burst_engine u_line_burst_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .line_req   (line_req),
        .line_cmd   (line_cmd),
        .line_ack   (line_ack),
        .line_rsp   (line_rsp),
        .word_req   (line_word_req),
        .word_cmd   (line_word_cmd),
        .word_ready (line_word_ready),
        .word_rdata (word_rdata),
        .word_error (word_error)
    );

    ptw_arbiter #(
        .NUM_WALKERS (NUM_WALKERS)
    ) u_ptw_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .ptw_req    (ptw_req),
        .ptw_cmd    (ptw_cmd),
        .ptw_ack    (ptw_ack),
        .ptw_rsp    (ptw_rsp),
        .word_req   (walk_word_req),
        .word_cmd   (walk_word_cmd),
        .word_ready (walk_word_ready),
        .word_rdata (word_rdata),
        .word_error (word_error)
    );

    mem_port_mux #(
        .NUM_WALKERS (NUM_WALKERS)
    ) u_mem_port_mux (
        .clk             (clk),
        .rst_n           (rst_n),
        .line_word_req   (line_word_req),
        .line_word_cmd   (line_word_cmd),
        .walk_word_req   (walk_word_req),
        .walk_word_cmd   (walk_word_cmd),
        .line_word_ready (line_word_ready),
        .walk_word_ready (walk_word_ready),
        .mem_request     (mem_request),
        .mem_cmd         (mem_cmd),
        .mem_ready       (mem_ready),
        .mem_read_data   (mem_read_data),
        .mem_error       (mem_error),
        .rdata           (word_rdata),
        .error           (word_error)
    );

endmodule

// ==== mem_ctrl/mem_port_mux.sv ====
`timescale 1ns/1ps

module mem_port_mux #(
    parameter int NUM_WALKERS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    // Requesters
    input  logic               line_word_req,
    input  mem_pkg::word_cmd_t line_word_cmd,
    input  logic               walk_word_req,
    input  mem_pkg::word_cmd_t walk_word_cmd,
    output logic               line_word_ready,
    output logic               walk_word_ready,
    // Memory port
    output logic               mem_request,
    output mem_pkg::word_cmd_t mem_cmd,
    input  logic               mem_ready,
    input  mem_pkg::word_t     mem_read_data,
    input  logic               mem_error,
    // Shared return path
    output mem_pkg::word_t     rdata,
    output logic               error
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_LINE,
        OWN_WALK
    } owner_t;

    localparam mem_pkg::word_idx_t LAST_IDX = mem_pkg::word_idx_t'(mem_pkg::LINE_WORDS - 1);

    owner_t             owner;
    mem_pkg::word_idx_t line_cnt;
    logic               xfer;

    if (NUM_WALKERS < 2 || NUM_WALKERS > 8) begin : g_walker_range
        $error("mem_port_mux supports 2 to 8 walkers");
    end

    // ========================================
    // Routing
    // ========================================
    assign mem_request = (owner == OWN_LINE) ? line_word_req :
                         (owner == OWN_WALK) ? walk_word_req : 1'b0;
    assign mem_cmd     = (owner == OWN_WALK) ? walk_word_cmd : line_word_cmd;
    assign xfer        = mem_request && mem_ready;

    assign line_word_ready = (owner == OWN_LINE) && xfer;
    assign walk_word_ready = (owner == OWN_WALK) && xfer;
    assign rdata           = mem_read_data;
    assign error           = mem_error;

    // ========================================
    // Ownership, line first when idle
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner    <= OWN_NONE;
            line_cnt <= '0;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (line_word_req) begin
                        owner    <= OWN_LINE;
                        line_cnt <= '0;
                    end else if (walk_word_req) begin
                        owner <= OWN_WALK;
                    end
                end
                OWN_LINE: begin
                    if (xfer) begin
                        line_cnt <= line_cnt + 1'b1;
                        // Hand over straight away if a walker waits
                        if (line_cnt == LAST_IDX) begin
                            owner <= walk_word_req ? OWN_WALK : OWN_NONE;
                        end
                    end
                end
                OWN_WALK: begin
                    if (xfer) begin
                        owner    <= line_word_req ? OWN_LINE : OWN_NONE;
                        line_cnt <= '0;
                    end
                end
                default: owner <= OWN_NONE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_request && !mem_ready) |=> (mem_request && $stable(mem_cmd)));

endmodule

// ==== mem_ctrl/ptw_arbiter.sv ====
`timescale 1ns/1ps

module ptw_arbiter #(
    parameter int NUM_WALKERS = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Walker ports, four-phase req/ack each
    input  logic [NUM_WALKERS-1:0]                 ptw_req,
    input  mem_pkg::word_cmd_t [NUM_WALKERS-1:0]   ptw_cmd,
    output logic [NUM_WALKERS-1:0]                 ptw_ack,
    output mem_pkg::word_rsp_t [NUM_WALKERS-1:0]   ptw_rsp,
    // Word channel towards the port mux
    output logic                                   word_req,
    output mem_pkg::word_cmd_t                     word_cmd,
    input  logic                                   word_ready,
    input  mem_pkg::word_t                         word_rdata,
    input  logic                                   word_error
);

    localparam int IDX_W = $clog2(NUM_WALKERS);

    logic [NUM_WALKERS-1:0] grant;
    logic [NUM_WALKERS-1:0] ack;
    logic [NUM_WALKERS-1:0] pick;
    logic [IDX_W-1:0]       last_idx;
    logic [IDX_W-1:0]       pick_idx;
    logic                   found;
    logic                   word_done;

    // ========================================
    // Round-robin pick
    // ========================================
    // Search starts just after the last walker served
    always_comb begin
        int cand;
        found    = 1'b0;
        pick_idx = '0;
        for (int i = 1; i <= NUM_WALKERS; i++) begin
            cand = (int'(last_idx) + i) % NUM_WALKERS;
            if (!found && ptw_req[cand]) begin
                found    = 1'b1;
                pick_idx = IDX_W'(cand);
            end
        end
        pick = '0;
        if (found) begin
            pick[pick_idx] = 1'b1;
        end
    end

    // ========================================
    // Grant and handshake
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant    <= '0;
            ack      <= '0;
            last_idx <= IDX_W'(NUM_WALKERS - 1);
        end else if (grant == '0) begin
            if (found) begin
                grant    <= pick;
                last_idx <= pick_idx;
            end
        end else if (ack == '0) begin
            if (word_done) begin
                ack <= grant;
            end
        end else if ((ack & ptw_req) == '0) begin
            // Walker released, free the slot for the next pick
            ack   <= '0;
            grant <= '0;
        end
    end

    assign word_req  = (grant != '0) && (ack == '0);
    assign word_done = word_req && word_ready;
    assign ptw_ack   = ack;

    always_comb begin
        word_cmd = '0;
        for (int j = 0; j < NUM_WALKERS; j++) begin
            if (grant[j]) begin
                word_cmd = ptw_cmd[j];
            end
        end
    end

    // Response held per port until the next word for that walker
    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_WALKERS; j++) begin
            if (word_done && grant[j]) begin
                ptw_rsp[j].rdata <= word_rdata;
                ptw_rsp[j].error <= word_error;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((ptw_ack & ~$past(ptw_req)) == '0));

endmodule

// ==== mem_ctrl/line_burst_engine.sv ====
`timescale 1ns/1ps

module line_burst_engine (
    input  logic               clk,
    input  logic               rst_n,
    // Line port, four-phase req/ack
    input  logic               line_req,
    input  mem_pkg::line_cmd_t line_cmd,
    output logic               line_ack,
    output mem_pkg::line_rsp_t line_rsp,
    // Word channel towards the port mux
    output logic               word_req,
    output mem_pkg::word_cmd_t word_cmd,
    input  logic               word_ready,
    input  mem_pkg::word_t     word_rdata,
    input  logic               word_error
);

    localparam int WORD_W = $bits(mem_pkg::word_t);
    localparam mem_pkg::word_idx_t LAST_IDX = mem_pkg::word_idx_t'(mem_pkg::LINE_WORDS - 1);

    mem_pkg::burst_state_t state;
    mem_pkg::word_idx_t    idx;
    mem_pkg::line_t        line_buf;
    logic                  err_acc;
    logic                  word_done;
    logic                  last_word;

    // ========================================
    // Word command generation
    // ========================================
    assign word_req  = (state == mem_pkg::READ_BURST) || (state == mem_pkg::WRITE_BURST);
    assign word_done = word_req && word_ready;
    assign last_word = (idx == LAST_IDX);

    // line_cmd is held by the requester until ack, so it can be used directly
    always_comb begin
        word_cmd.addr  = line_cmd.addr
                       + mem_pkg::addr_t'(idx) * mem_pkg::addr_t'(mem_pkg::WORD_BYTES);
        word_cmd.wdata = line_cmd.wdata[int'(idx)*WORD_W +: WORD_W];
        word_cmd.write = (state == mem_pkg::WRITE_BURST);
    end

    // ========================================
    // Burst FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= mem_pkg::IDLE;
            idx     <= '0;
            err_acc <= 1'b0;
        end else begin
            case (state)
                mem_pkg::IDLE: begin
                    if (line_req) begin
                        idx     <= '0;
                        err_acc <= 1'b0;
                        state   <= line_cmd.write ? mem_pkg::WRITE_BURST : mem_pkg::READ_BURST;
                    end
                end
                mem_pkg::READ_BURST, mem_pkg::WRITE_BURST: begin
                    if (word_done) begin
                        idx     <= idx + 1'b1;
                        err_acc <= err_acc | word_error;
                        if (last_word) begin
                            state <= mem_pkg::RESPOND;
                        end
                    end
                end
                mem_pkg::RESPOND: begin
                    // Ack drops one cycle after req is seen low
                    if (!line_req) begin
                        state <= mem_pkg::IDLE;
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    // Read words land in their slot of the line
    always_ff @(posedge clk) begin
        if (state == mem_pkg::READ_BURST && word_ready) begin
            line_buf[int'(idx)*WORD_W +: WORD_W] <= word_rdata;
        end
    end

    // ========================================
    // Line response
    // ========================================
    assign line_ack       = (state == mem_pkg::RESPOND);
    assign line_rsp.rdata = line_buf;
    assign line_rsp.error = err_acc;

    // Memory side must see a steady command while stalled
    assert property (@(posedge clk) disable iff (!rst_n)
        (word_req && !word_ready) |=> (word_req && $stable(word_cmd)));

endmodule

// ==== common/mem_pkg.sv ====
package mem_pkg;

    // ========================================
    // Geometry
    // ========================================
    localparam int WORD_BYTES = 8;
    localparam int LINE_WORDS = 8;

    // ========================================
    // Plain vector types
    // ========================================
    typedef logic [31:0]                   addr_t;
    typedef logic [WORD_BYTES*8-1:0]       word_t;
    typedef logic [LINE_WORDS*$bits(word_t)-1:0] line_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;

    // ========================================
    // Channel payloads
    // ========================================
    // Word access for memory and walker ports
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } word_cmd_t;

    // Whole line, addr is line aligned and word k sits at bit k*64
    typedef struct packed {
        addr_t addr;
        line_t wdata;
        logic  write;
    } line_cmd_t;

    typedef struct packed {
        line_t rdata;
        logic  error;
    } line_rsp_t;

    typedef struct packed {
        word_t rdata;
        logic  error;
    } word_rsp_t;

    // Line burst FSM
    typedef enum logic [1:0] {
        IDLE,
        READ_BURST,
        WRITE_BURST,
        RESPOND
    } burst_state_t;

endpackage
